/* all.f */
design/pin_bus_pkg.sv
design/addr_lane.sv
design/data_lane.sv
design/apb_bridge.sv
design/pin_bus_top.sv
verif/pin_device_model.sv
verif/tb_pin_bus.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run; exit status is nonzero on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_pin_bus \
  -Mdir obj_dir \
  -f all.f \
  && ./obj_dir/Vtb_pin_bus \
  || exit 1

/* verif/tb_pin_bus.sv */
module tb_pin_bus
  import pin_bus_pkg::*;
();

  localparam int          WAIT_CYCLES = 2;
  localparam int          N_TX        = 12;
  localparam int          MEM_DEPTH   = 256;
  localparam int          IDX_W       = $clog2(MEM_DEPTH);
  localparam logic [31:0] FILL_KEY    = 32'hA5A50000;
  localparam logic [31:0] SEED        = 32'h611e1673;
  localparam int          TIMEOUT     = N_TX * (12 + WAIT_CYCLES) + 40;

  logic              clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [WORD_W-1:0] paddr;
  logic [WORD_W-1:0] pwdata;
  logic [WORD_W-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [7:0]        uio_in;
  logic [7:0]        uo_out;
  logic [7:0]        uio_out;
  logic [7:0]        uio_oe;
  logic              bus_active;
  logic              pin_err;
  int                cycle_cnt;
  int                n_entries;

  // transaction table
  logic        tab_wr    [N_TX];
  logic [31:0] tab_addr  [N_TX];
  logic [31:0] tab_wdata [N_TX];
  logic [31:0] tab_exp   [N_TX];
  logic        tab_err   [N_TX];
  logic [31:0] shadow    [MEM_DEPTH];  // expected device contents

  pin_bus_top #(
    .WAIT_CYCLES(WAIT_CYCLES)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .uio_in    (uio_in),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .bus_active(bus_active)
  );

  pin_device_model #(
    .WAIT_CYCLES(WAIT_CYCLES),
    .MEM_DEPTH  (MEM_DEPTH),
    .FILL_KEY   (FILL_KEY)
  ) u_device (
    .clk       (clk),
    .bus_active(bus_active),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .uio_in    (uio_in),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pin_err   (pin_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // expected values follow the device memory rules and misaligned never touches it
  task automatic add_entry(input logic wr, input logic [31:0] addr);
    logic [IDX_W-1:0] idx;
    idx                  = addr[IDX_W+1:2];
    tab_wr[n_entries]    = wr;
    tab_addr[n_entries]  = addr;
    tab_wdata[n_entries] = $urandom();
    tab_err[n_entries]   = (addr[1:0] != 2'b00);
    if (tab_err[n_entries] || wr) begin
      tab_exp[n_entries] = '0;
    end else begin
      tab_exp[n_entries] = shadow[idx];
    end
    if (!tab_err[n_entries] && wr) begin
      shadow[idx] = tab_wdata[n_entries];
    end
    n_entries++;
  endtask

  task automatic run_entry(input int i);
    int waited;
    int exp_lat;
    exp_lat = tab_err[i] ? 1 : 10 + WAIT_CYCLES;
    @(posedge clk);
    #1;
    check_value("pready", 32'(pready), 32'd0);  // one-cycle pulse only
    psel    = 1'b1;  // setup
    penable = 1'b0;
    pwrite  = tab_wr[i];
    paddr   = tab_addr[i];
    pwdata  = tab_wdata[i];
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited  = 0;
    while (pready !== 1'b1) begin
      if (tab_err[i]) begin
        check_value("bus_active", 32'(bus_active), 32'd0);
      end
      @(posedge clk);
      #1;
      waited++;
    end
    if (tab_err[i]) begin
      check_value("bus_active", 32'(bus_active), 32'd0);
    end
    check_value("pready latency", 32'(waited), 32'(exp_lat));
    check_value("pslverr", 32'(pslverr), 32'(tab_err[i]));
    check_value("prdata", prdata, tab_exp[i]);
  endtask

  initial begin
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    n_entries = 0;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_DEPTH; i++) begin
      shadow[i] = FILL_KEY ^ 32'(i);
    end

    add_entry(1'b1, 32'h0000_0010);
    add_entry(1'b0, 32'h0000_0010);  // read back
    add_entry(1'b0, 32'h0000_0040);  // never written
    add_entry(1'b0, 32'h0000_0042);  // misaligned
    add_entry(1'b1, 32'h1234_5678);
    add_entry(1'b0, 32'h1234_5678);
    add_entry(1'b1, 32'h0000_0101);  // misaligned write leaves memory untouched
    add_entry(1'b0, 32'h0000_0100);
    add_entry(1'b1, 32'hFFFF_FFFC);
    add_entry(1'b1, 32'h0000_0010);  // overwrite
    add_entry(1'b0, 32'h0000_0010);
    add_entry(1'b0, 32'hFFFF_FFFC);

    repeat (16) @(posedge clk);
    #1;
    check_value("pready", 32'(pready), 32'd0);
    check_value("pslverr", 32'(pslverr), 32'd0);
    check_value("bus_active", 32'(bus_active), 32'd0);
    check_value("uio_oe", 32'(uio_oe), 32'd0);
    check_value("uo_out", 32'(uo_out), 32'd0);
    check_value("uio_out", 32'(uio_out), 32'd0);
    check_value("phase", 32'(uut.u_bridge.phase), 32'(PH_IDLE));
    rst = 1'b0;

    // back to back with no idle cycles between entries
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    check_value("pready", 32'(pready), 32'd0);
    repeat (2) @(posedge clk);

    $display("Done: no errors");
    $finish;
  end

  // device model flags bad frames
  initial begin
    wait (pin_err === 1'b1);
    $display("Done: errors found");
    $fatal(1, "pin-side frame check failed");
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: transactions still running after %0d cycles", cycle_cnt);
    $display("Done: errors found");
    $fatal(1, "simulation timed out");
  end

endmodule

/* verif/pin_device_model.sv */
module pin_device_model #(
  parameter int          WAIT_CYCLES = 0,
  parameter int          MEM_DEPTH   = 256,
  parameter logic [31:0] FILL_KEY    = 32'h0
) (
  input  logic        clk,
  input  logic        bus_active,
  input  logic [7:0]  uo_out,
  input  logic [7:0]  uio_out,
  input  logic [7:0]  uio_oe,
  output logic [7:0]  uio_in,
  // APB request for cross-checking what shows up on the pins
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  output logic        pin_err
);

  localparam int IDX_W     = $clog2(MEM_DEPTH);
  localparam int CAP_FIRST = 6 + WAIT_CYCLES;  // frame cycle of capture byte 0
  localparam int LAST      = 10 + WAIT_CYCLES; // completion cycle

  logic [31:0] mem [MEM_DEPTH];
  logic [31:0] pin_addr;
  logic [31:0] pin_wdata;
  logic        active_q;
  int          k;  // cycles since bus_active rose or -1 between frames

  task automatic report(input string what);
    $display("pin device: %s (time %0t)", what, $time);
    pin_err = 1'b1;
  endtask

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = FILL_KEY ^ 32'(i);
    end
    uio_in    = '0;
    pin_err   = 1'b0;
    active_q  = 1'b0;
    pin_addr  = '0;
    pin_wdata = '0;
    k         = -1;
    forever begin
      @(posedge clk);
      #1;  // look at the pins mid-cycle
      if (bus_active && !active_q) begin
        k = 0;  // first access cycle
      end else if (k >= 0 && k < LAST) begin
        k++;
      end else begin
        k = -1;
      end
      active_q = bus_active;

      if (k >= 1 && k <= 4) begin
        pin_addr[8*(k-1) +: 8]  = uo_out;   // lsb first
        pin_wdata[8*(k-1) +: 8] = uio_out;
        if (pwrite && uio_oe != 8'hff) begin
          report("uio_oe not all ones in a write beat");
        end
        if (!pwrite && uio_oe != 8'h00) begin
          report("uio_oe driven during a read frame");
        end
      end else if (k >= 0 && uio_oe != 8'h00) begin
        report("uio_oe driven outside the write beats");
      end

      if (k == 4 && pin_addr != paddr) begin
        report($sformatf("address 0x%08h on the pins differs from paddr 0x%08h",
                         pin_addr, paddr));
      end
      if (k == 4 && pwrite && pin_wdata != pwdata) begin
        report($sformatf("write data 0x%08h on the pins differs from pwdata 0x%08h",
                         pin_wdata, pwdata));
      end

      if (k == 5) begin
        if (uo_out != {7'b0, pwrite}) begin
          report($sformatf("command beat 0x%02h does not match pwrite %0b", uo_out, pwrite));
        end else if (uo_out[0]) begin
          mem[pin_addr[IDX_W+1:2]] = pin_wdata;
        end
      end

      // answer with the addressed word one byte per capture beat
      if (k >= CAP_FIRST && k < CAP_FIRST + 4) begin
        uio_in = mem[pin_addr[IDX_W+1:2]][8*(k-CAP_FIRST) +: 8];
      end else begin
        uio_in = '0;
      end
    end
  end

endmodule

/* design/pin_bus_top.sv */
module pin_bus_top
  import pin_bus_pkg::*;
#(
  parameter int WAIT_CYCLES = 0  // 0 to 7 turn beats before capture
) (
  input  logic              clk,
  input  logic              rst,
  // APB side
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [WORD_W-1:0] paddr,
  input  logic [WORD_W-1:0] pwdata,
  output logic [WORD_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  // pin side
  input  logic [PIN_W-1:0]  uio_in,
  output logic [PIN_W-1:0]  uo_out,
  output logic [PIN_W-1:0]  uio_out,
  output logic [PIN_W-1:0]  uio_oe,
  output logic              bus_active
);

  logic [3:0] phase;
  logic       wr_flag;
  bus_word_u  addr_word;
  bus_word_u  wdata_word;
  bus_word_u  rdata_word;   // captured read word back from the data lane

  apb_bridge #(
    .WAIT_CYCLES(WAIT_CYCLES)
  ) u_bridge (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .phase     (phase),
    .addr_word (addr_word),
    .wdata_word(wdata_word),
    .wr_flag   (wr_flag),
    .bus_active(bus_active),
    .rdata_word(rdata_word)
  );

  // address bytes and command on the dedicated outputs
  addr_lane u_addr_lane (
    .clk      (clk),
    .rst      (rst),
    .phase    (phase),
    .addr_word(addr_word),
    .wr_flag  (wr_flag),
    .uo_out   (uo_out)
  );

  // write bytes out and read bytes in over the bidir pins
  data_lane u_data_lane (
    .clk       (clk),
    .rst       (rst),
    .phase     (phase),
    .wdata_word(wdata_word),
    .wr_flag   (wr_flag),
    .uio_in    (uio_in),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .rdata_word(rdata_word)
  );

endmodule

/* design/apb_bridge.sv */
module apb_bridge
  import pin_bus_pkg::*;
#(
  parameter int WAIT_CYCLES = 0
) (
  input  logic              clk,
  input  logic              rst,
  // APB completer
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [WORD_W-1:0] paddr,
  input  logic [WORD_W-1:0] pwdata,
  output logic [WORD_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  // towards the lanes
  output logic [3:0]        phase,
  output bus_word_u         addr_word,
  output bus_word_u         wdata_word,
  output logic              wr_flag,
  output logic              bus_active,
  input  bus_word_u         rdata_word
);

  // last count value before the capture beats start
  localparam logic [2:0] TURN_LAST = 3'(WAIT_CYCLES - 1);

  logic       setup;       // APB setup cycle
  logic       misaligned;
  logic       err_q;       // current transfer was refused
  logic [2:0] turn_cnt;

  // starting on the setup cycle lets the registered lanes hit the pins
  // in the cycle right after the first access cycle
  assign setup      = psel && !penable;
  assign misaligned = (paddr[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase    <= PH_IDLE;
      turn_cnt <= '0;
      err_q    <= 1'b0;
      wr_flag  <= 1'b0;
      pready   <= 1'b0;
      pslverr  <= 1'b0;
    end else begin
      pready  <= (phase == PH_DONE);          // single cycle as phase leaves DONE at once
      pslverr <= (phase == PH_DONE) && err_q;

      case (phase)
        PH_IDLE: begin
          if (setup) begin
            err_q   <= misaligned;
            wr_flag <= pwrite;
            // refused access skips the frame entirely
            phase   <= misaligned ? PH_DONE : PH_BEAT0;
          end
        end
        PH_BEAT0, PH_BEAT1, PH_BEAT2: phase <= phase + 4'd1;
        PH_BEAT3: phase <= PH_CMD;
        PH_CMD: begin
          turn_cnt <= '0;
          phase    <= (WAIT_CYCLES == 0) ? PH_CAP0 : PH_TURN;
        end
        PH_TURN: begin
          if (turn_cnt == TURN_LAST) begin
            phase <= PH_CAP0;
          end else begin
            turn_cnt <= turn_cnt + 3'd1;
          end
        end
        PH_CAP0, PH_CAP1, PH_CAP2: phase <= phase + 4'd1;
        PH_CAP3: phase <= PH_DONE;
        default: phase <= PH_IDLE;  // DONE and unused codes
      endcase
    end
  end

  // address and write data held for the whole frame
  always_ff @(posedge clk) begin
    if (phase == PH_IDLE && setup && !misaligned) begin
      addr_word.word  <= paddr;
      wdata_word.word <= pwdata;
    end
  end

  // frame marker for the pin-side device
  assign bus_active = (phase >= PH_BEAT0) && (phase <= PH_CAP3);

  // the last capture byte lands together with pready
  assign prdata = (pready && !wr_flag && !err_q) ? rdata_word.word : '0;

endmodule

/* design/data_lane.sv */
module data_lane
  import pin_bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       phase,
  input  bus_word_u        wdata_word,
  input  logic             wr_flag,
  input  logic [PIN_W-1:0] uio_in,
  output logic [PIN_W-1:0] uio_out,
  output logic [PIN_W-1:0] uio_oe,
  output bus_word_u        rdata_word
);

  logic [3:0]               phase_q;   // phase as seen on the pins
  logic [$clog2(BEATS)-1:0] beat_idx;
  logic [$clog2(BEATS)-1:0] cap_idx;
  logic                     wr_beat;   // this beat drives write data
  logic                     cap_beat;

  assign beat_idx = $clog2(BEATS)'(phase - PH_BEAT0);
  assign cap_idx  = $clog2(BEATS)'(phase_q - PH_CAP0);
  assign wr_beat  = wr_flag && (phase >= PH_BEAT0) && (phase <= PH_BEAT3);
  assign cap_beat = (phase_q >= PH_CAP0) && (phase_q <= PH_CAP3);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= PH_IDLE;
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      phase_q <= phase;
      if (wr_beat) begin
        uio_out <= wdata_word.bytes[beat_idx];
        uio_oe  <= '1;
      end else begin
        // pins released for the command, wait and capture beats
        uio_out <= '0;
        uio_oe  <= '0;
      end
    end
  end

  // device answers one cycle after the capture code, so sample on phase_q
  always_ff @(posedge clk) begin
    if (phase == PH_BEAT0) begin
      rdata_word <= '0;                  // new frame
    end else if (cap_beat) begin
      rdata_word.bytes[cap_idx] <= uio_in;
    end
  end

endmodule

/* design/addr_lane.sv */
module addr_lane
  import pin_bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       phase,
  input  bus_word_u        addr_word,
  input  logic             wr_flag,
  output logic [PIN_W-1:0] uo_out
);

  logic [$clog2(BEATS)-1:0] beat_idx;

  // beat codes are consecutive, so the offset picks the byte
  assign beat_idx = $clog2(BEATS)'(phase - PH_BEAT0);

  always_ff @(posedge clk) begin
    if (rst) begin
      uo_out <= '0;
    end else begin
      case (phase)
        PH_BEAT0, PH_BEAT1, PH_BEAT2, PH_BEAT3: begin
          uo_out <= addr_word.bytes[beat_idx];  // lsb first
        end
        PH_CMD, PH_TURN: begin
          // command held through the wait beats
          uo_out <= {{(PIN_W-1){1'b0}}, wr_flag};
        end
        default: uo_out <= '0;
      endcase
    end
  end

endmodule

/* design/pin_bus_pkg.sv */
package pin_bus_pkg;

  localparam int PIN_W  = 8;               // pin byte width
  localparam int WORD_W = 32;              // processor bus width
  localparam int BEATS  = WORD_W / PIN_W;  // bytes per word with one beat each

  // frame position codes carried on phase
  localparam logic [3:0] PH_IDLE  = 4'd0;
  localparam logic [3:0] PH_BEAT0 = 4'd1;  // address byte 0 and write byte 0
  localparam logic [3:0] PH_BEAT1 = 4'd2;
  localparam logic [3:0] PH_BEAT2 = 4'd3;
  localparam logic [3:0] PH_BEAT3 = 4'd4;
  localparam logic [3:0] PH_CMD   = 4'd5;  // write flag on bit 0
  localparam logic [3:0] PH_TURN  = 4'd6;  // wait beats for slow devices
  localparam logic [3:0] PH_CAP0  = 4'd7;  // read byte 0
  localparam logic [3:0] PH_CAP1  = 4'd8;
  localparam logic [3:0] PH_CAP2  = 4'd9;
  localparam logic [3:0] PH_CAP3  = 4'd10;
  localparam logic [3:0] PH_DONE  = 4'd11;

  // same 32 bits seen as one value or as the byte of each beat
  typedef union packed {
    logic [WORD_W-1:0]           word;
    logic [BEATS-1:0][PIN_W-1:0] bytes;  // bytes[0] goes out first
  } bus_word_u;

endpackage
